// ==== dcache_top.f ====
rtl/dcache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/dcache_array.sv
rtl/miss_queue.sv
rtl/dcache_controller.sv
rtl/dcache_top.sv
verif/dcache_checker.sv
verif/dcache_tb.sv

// ==== Makefile ====
TOP := dcache_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f dcache_top.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f dcache_top.f

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int num_slots = 64;
  localparam int num_loads = 200;
  localparam int num_mixed = 600;
  localparam int cycles_per_access = 24;
  localparam int flush_cycles = 800;
  localparam int watchdog_cycles = (num_loads + num_mixed) * cycles_per_access + flush_cycles;

  logic                      clock;
  logic                      reset;
  logic                      load_valid;
  dcache_pkg::addr_t         load_addr;
  logic                      load_hit;
  dcache_pkg::word_t         load_data;
  logic                      store_valid;
  dcache_pkg::addr_t         store_addr;
  dcache_pkg::word_t         store_data;
  logic                      store_done;
  logic                      flush;
  logic                      flush_done;
  mem_bus_pkg::bus_command_t mem_command;
  dcache_pkg::addr_t         mem_addr;
  dcache_pkg::word_t         mem_wdata;
  mem_bus_pkg::mem_tag_t     mem_response;
  mem_bus_pkg::mem_tag_t     mem_tag;
  dcache_pkg::word_t         mem_rdata;

  // backing memory and the architectural values the processor expects
  dcache_pkg::word_t mem_words [num_slots];
  dcache_pkg::word_t ref_words [num_slots];
  logic [31:0]       stim_rng;

  dcache_top dut_i (
    .clock(clock),
    .reset(reset),
    .load_valid(load_valid),
    .load_addr(load_addr),
    .load_hit(load_hit),
    .load_data(load_data),
    .store_valid(store_valid),
    .store_addr(store_addr),
    .store_data(store_data),
    .store_done(store_done),
    .flush(flush),
    .flush_done(flush_done),
    .mem_command(mem_command),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_response(mem_response),
    .mem_tag(mem_tag),
    .mem_rdata(mem_rdata)
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic dcache_pkg::addr_t slot_addr(input int slot);
    return dcache_pkg::addr_t'(slot) << dcache_pkg::offset_bits;
  endfunction

  // power-on memory word, built from the full byte address
  function automatic dcache_pkg::word_t fill_pattern(input dcache_pkg::addr_t addr);
    return {addr ^ 32'h5a5a0000, ~addr};
  endfunction

  task automatic stop_run();
    $display("tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t expected);
    assert (got === expected) else begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, expected, got);
      stop_run();
    end
  endtask

  task automatic expect_low(input string name, input logic got);
    assert (got === 1'b0) else begin
      $display("Fail at %0t: %s expected 0 got %b", $time, name, got);
      stop_run();
    end
  endtask

  // hold the load until it hits, then check the returned word
  task automatic load_access(input int slot);
    load_valid = 1'b1;
    load_addr = slot_addr(slot);
    #1;
    while (load_hit !== 1'b1) begin
      @(negedge clock);
      #1;
    end
    compare_word("load_data", load_data, ref_words[slot]);
    @(negedge clock);
    load_valid = 1'b0;
  endtask

  task automatic store_access(input int slot, input dcache_pkg::word_t data);
    store_valid = 1'b1;
    store_addr = slot_addr(slot);
    store_data = data;
    #1;
    while (store_done !== 1'b1) begin
      @(negedge clock);
      #1;
    end
    ref_words[slot] = data;
    @(negedge clock);
    store_valid = 1'b0;
  endtask

  // tagged memory, random acceptance, loads return after 1 to 6 cycles
  initial begin : memory_model
    logic [31:0]           mem_rng;
    logic                  tag_busy [16];
    int                    tag_delay [16];
    dcache_pkg::word_t     tag_data [16];
    mem_bus_pkg::mem_tag_t free_tag;
    int                    slot;
    mem_rng = xorshift(xorshift(32'ha381));
    mem_response = '0;
    mem_tag = '0;
    mem_rdata = '0;
    for (int i = 0; i < 16; i++) begin
      tag_busy[i] = 1'b0;
      tag_delay[i] = 0;
      tag_data[i] = '0;
    end
    for (int i = 0; i < num_slots; i++) begin
      mem_words[i] = fill_pattern(slot_addr(i));
    end
    forever begin
      @(negedge clock);
      mem_rng = xorshift(mem_rng);
      mem_response = '0;
      // the tag shown last cycle is done
      if (mem_tag != '0) begin
        tag_busy[mem_tag] = 1'b0;
        mem_tag = '0;
      end
      if (!reset) begin
        for (int i = 1; i < 16; i++) begin
          if (tag_busy[i] && tag_delay[i] > 0) tag_delay[i]--;
        end
        for (int i = 1; i < 16; i++) begin
          if (mem_tag == '0 && tag_busy[i] && tag_delay[i] == 0) begin
            mem_tag = mem_bus_pkg::mem_tag_t'(i);
            mem_rdata = tag_data[i];
          end
        end
        free_tag = '0;
        for (int i = 15; i > 0; i--) begin
          if (!tag_busy[i]) free_tag = mem_bus_pkg::mem_tag_t'(i);
        end
        if (mem_command != mem_bus_pkg::bus_none && mem_rng[1:0] != 2'b00 && free_tag != '0) begin
          assert (mem_addr < slot_addr(num_slots) && mem_addr[2:0] == 3'b000) else begin
            $display("memory command at %0t to address %h outside the modelled range",
                     $time, mem_addr);
            stop_run();
          end
          slot = int'(mem_addr >> dcache_pkg::offset_bits);
          mem_response = free_tag;
          if (mem_command == mem_bus_pkg::bus_store) begin
            mem_words[slot] = mem_wdata;
          end else begin
            tag_busy[free_tag] = 1'b1;
            tag_delay[free_tag] = 1 + int'(mem_rng[10:8]) % 6;
            tag_data[free_tag] = mem_words[slot];
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clock);
    $display("watchdog expired after %0d cycles without finishing", watchdog_cycles);
    $display("tests failed");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    int                slot;
    dcache_pkg::word_t data;
    stim_rng = 32'ha381;
    reset = 1'b1;
    load_valid = 1'b0;
    load_addr = '0;
    store_valid = 1'b0;
    store_addr = '0;
    store_data = '0;
    flush = 1'b0;
    for (int i = 0; i < num_slots; i++) begin
      ref_words[i] = fill_pattern(slot_addr(i));
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #1;
    expect_low("load_hit", load_hit);
    expect_low("store_done", store_done);
    expect_low("flush_done", flush_done);
    assert (mem_command == mem_bus_pkg::bus_none) else begin
      $display("Fail at %0t: mem_command expected %0d got %0d", $time,
               mem_bus_pkg::bus_none, mem_command);
      stop_run();
    end
    @(negedge clock);

    // loads only, every line comes from memory
    repeat (num_loads) begin
      stim_rng = xorshift(stim_rng);
      load_access(int'(stim_rng[5:0]));
    end

    // 4 addresses share each index, so dirty lines get written back
    repeat (num_mixed) begin
      stim_rng = xorshift(stim_rng);
      slot = int'(stim_rng[5:0]);
      if (stim_rng[8]) begin
        stim_rng = xorshift(stim_rng);
        data[63:32] = stim_rng;
        stim_rng = xorshift(stim_rng);
        data[31:0] = stim_rng;
        store_access(slot, data);
      end else begin
        load_access(slot);
      end
    end

    // slots 5 and 9 sit on different indexes and stay resident through the flush
    load_access(5);
    store_access(9, ~ref_words[9]);

    flush = 1'b1;
    @(negedge clock);
    flush = 1'b0;
    while (flush_done !== 1'b1) @(negedge clock);
    for (int i = 0; i < num_slots; i++) begin
      compare_word($sformatf("mem_words[%0d]", i), mem_words[i], ref_words[i]);
    end

    // cache stays closed after the flush, even for resident lines
    load_valid = 1'b1;
    load_addr = slot_addr(5);
    store_valid = 1'b1;
    store_addr = slot_addr(9);
    store_data = '1;
    repeat (4) begin
      #1;
      expect_low("load_hit", load_hit);
      expect_low("store_done", store_done);
      @(negedge clock);
    end
    load_valid = 1'b0;
    store_valid = 1'b0;

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/dcache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
  input wire logic                      clock,
  input wire logic                      reset,
  input wire logic                      flush,
  input wire logic                      flush_done,
  input wire logic                      load_hit,
  input wire logic                      store_done,
  input wire logic                      fill_valid,
  input wire logic                      fill_taken,
  input wire mem_bus_pkg::bus_command_t mem_command
);

  // set by the first flush, cleared only by reset
  logic flush_seen;

  always_ff @(posedge clock) begin
    if (reset) begin
      flush_seen <= 1'b0;
    end else if (flush) begin
      flush_seen <= 1'b1;
    end
  end

  command_legal: assert property (@(posedge clock) disable iff (reset)
    mem_command inside {mem_bus_pkg::bus_none, mem_bus_pkg::bus_load, mem_bus_pkg::bus_store})
    else $error("memory command has an illegal encoding");

  done_holds: assert property (@(posedge clock) disable iff (reset)
    flush_done |=> flush_done)
    else $error("flush_done fell without a reset");

  closed_after_flush: assert property (@(posedge clock) disable iff (reset)
    (flush || flush_seen) |-> (!load_hit && !store_done))
    else $error("processor access answered after a flush");

  // a returned fill stays presented until the cache writes it
  fill_held: assert property (@(posedge clock) disable iff (reset)
    (fill_valid && !fill_taken) |=> fill_valid)
    else $error("fill withdrawn before it was taken");

endmodule

bind dcache_top dcache_checker checker_i (
  .clock(clock),
  .reset(reset),
  .flush(flush),
  .flush_done(flush_done),
  .load_hit(load_hit),
  .store_done(store_done),
  .fill_valid(fill_valid),
  .fill_taken(fill_taken),
  .mem_command(mem_command)
);

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  load_valid,
  input  wire dcache_pkg::addr_t     load_addr,
  output logic                       load_hit,
  output dcache_pkg::word_t          load_data,
  input  wire logic                  store_valid,
  input  wire dcache_pkg::addr_t     store_addr,
  input  wire dcache_pkg::word_t     store_data,
  output logic                       store_done,
  input  wire logic                  flush,
  output logic                       flush_done,
  output mem_bus_pkg::bus_command_t  mem_command,
  output dcache_pkg::addr_t          mem_addr,
  output dcache_pkg::word_t          mem_wdata,
  input  wire mem_bus_pkg::mem_tag_t mem_response,
  input  wire mem_bus_pkg::mem_tag_t mem_tag,
  input  wire dcache_pkg::word_t     mem_rdata
);

  // array side
  logic              load_match;
  logic              store_match;
  logic              victim_valid;
  logic              victim_dirty;
  dcache_pkg::addr_t victim_addr;
  dcache_pkg::word_t victim_data;
  logic              write_en;
  dcache_pkg::addr_t write_addr;
  dcache_pkg::word_t write_data;
  logic              write_dirty;
  logic              write_clean_only;

  // queue side
  logic              push_fill;
  dcache_pkg::addr_t fill_req_addr;
  logic              push_evict;
  dcache_pkg::addr_t evict_addr;
  dcache_pkg::word_t evict_data;
  logic              fill_taken;
  logic              queue_full;
  logic              queue_empty;
  logic              fill_valid;
  dcache_pkg::addr_t fill_addr;
  dcache_pkg::word_t fill_data;

  dcache_controller controller_i (
    .clock(clock),
    .reset(reset),
    .load_valid(load_valid),
    .load_addr(load_addr),
    .store_valid(store_valid),
    .store_addr(store_addr),
    .store_data(store_data),
    .flush(flush),
    .load_match(load_match),
    .store_match(store_match),
    .victim_valid(victim_valid),
    .victim_dirty(victim_dirty),
    .victim_addr(victim_addr),
    .victim_data(victim_data),
    .queue_full(queue_full),
    .queue_empty(queue_empty),
    .fill_valid(fill_valid),
    .fill_addr(fill_addr),
    .fill_data(fill_data),
    .load_hit(load_hit),
    .store_done(store_done),
    .flush_done(flush_done),
    .write_en(write_en),
    .write_addr(write_addr),
    .write_data(write_data),
    .write_dirty(write_dirty),
    .write_clean_only(write_clean_only),
    .push_fill(push_fill),
    .fill_req_addr(fill_req_addr),
    .push_evict(push_evict),
    .evict_addr(evict_addr),
    .evict_data(evict_data),
    .fill_taken(fill_taken)
  );

  dcache_array array_i (
    .clock(clock),
    .reset(reset),
    .load_addr(load_addr),
    .store_addr(store_addr),
    .write_en(write_en),
    .write_addr(write_addr),
    .write_data(write_data),
    .write_dirty(write_dirty),
    .write_clean_only(write_clean_only),
    .load_data(load_data),
    .load_match(load_match),
    .store_match(store_match),
    .victim_valid(victim_valid),
    .victim_dirty(victim_dirty),
    .victim_addr(victim_addr),
    .victim_data(victim_data)
  );

  miss_queue queue_i (
    .clock(clock),
    .reset(reset),
    .push_fill(push_fill),
    .fill_req_addr(fill_req_addr),
    .push_evict(push_evict),
    .evict_addr(evict_addr),
    .evict_data(evict_data),
    .fill_taken(fill_taken),
    .mem_response(mem_response),
    .mem_tag(mem_tag),
    .mem_rdata(mem_rdata),
    .queue_full(queue_full),
    .queue_empty(queue_empty),
    .fill_valid(fill_valid),
    .fill_addr(fill_addr),
    .fill_data(fill_data),
    .mem_command(mem_command),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata)
  );

endmodule

`default_nettype wire

// ==== rtl/dcache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_controller (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic              load_valid,
  input  wire dcache_pkg::addr_t load_addr,
  input  wire logic              store_valid,
  input  wire dcache_pkg::addr_t store_addr,
  input  wire dcache_pkg::word_t store_data,
  input  wire logic              flush,
  input  wire logic              load_match,
  input  wire logic              store_match,
  input  wire logic              victim_valid,
  input  wire logic              victim_dirty,
  input  wire dcache_pkg::addr_t victim_addr,
  input  wire dcache_pkg::word_t victim_data,
  input  wire logic              queue_full,
  input  wire logic              queue_empty,
  input  wire logic              fill_valid,
  input  wire dcache_pkg::addr_t fill_addr,
  input  wire dcache_pkg::word_t fill_data,
  output logic                   load_hit,
  output logic                   store_done,
  output logic                   flush_done,
  output logic                   write_en,
  output dcache_pkg::addr_t      write_addr,
  output dcache_pkg::word_t      write_data,
  output logic                   write_dirty,
  output logic                   write_clean_only,
  output logic                   push_fill,
  output dcache_pkg::addr_t      fill_req_addr,
  output logic                   push_evict,
  output dcache_pkg::addr_t      evict_addr,
  output dcache_pkg::word_t      evict_data,
  output logic                   fill_taken
);

  dcache_pkg::flush_state_t state;
  dcache_pkg::flush_state_t state_next;
  dcache_pkg::index_t       walk_index;

  logic active;
  logic victim_needs_evict;
  logic fill_write;
  logic walk_write;
  logic store_write;
  logic load_miss;
  logic store_miss;

  // processor is served only before any flush
  assign active = (state == dcache_pkg::state_idle) && !flush;
  assign victim_needs_evict = victim_valid && victim_dirty;

  // write port priority is fill, then walk, then store
  assign fill_write = fill_valid && !(victim_needs_evict && queue_full);
  assign walk_write = (state == dcache_pkg::state_walk) && !fill_valid && !queue_full;
  assign store_write = active && store_valid && store_match && !fill_valid;

  assign load_hit = active && load_valid && load_match;
  assign store_done = store_write;
  assign load_miss = active && load_valid && !load_match;
  assign store_miss = active && store_valid && !store_match;

  // displaced dirty line goes out as an eviction
  assign fill_taken = fill_write;
  assign push_evict = (fill_write || walk_write) && victim_needs_evict;
  assign evict_addr = victim_addr;
  assign evict_data = victim_data;

  // one push per cycle, loads ask first
  assign push_fill = (load_miss || store_miss) && !push_evict && !queue_full;
  assign fill_req_addr = load_miss ? load_addr : store_addr;

  assign flush_done = (state == dcache_pkg::state_done);
  assign write_en = fill_write || walk_write || store_write;

  // address also selects the victim, so it follows fill_valid even while the fill waits
  always_comb begin
    write_addr = store_addr;
    write_data = store_data;
    write_dirty = 1'b1;
    write_clean_only = 1'b0;
    if (fill_valid) begin
      write_addr = fill_addr;
      write_data = fill_data;
      write_dirty = 1'b0;
    end else if (state == dcache_pkg::state_walk) begin
      write_addr = {{dcache_pkg::tag_bits{1'b0}}, walk_index, {dcache_pkg::offset_bits{1'b0}}};
      write_dirty = 1'b0;
      write_clean_only = 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      dcache_pkg::state_idle: if (flush) state_next = dcache_pkg::state_drain;
      dcache_pkg::state_drain: if (queue_empty) state_next = dcache_pkg::state_walk;
      dcache_pkg::state_walk: begin
        if (walk_write && walk_index == dcache_pkg::last_index) begin
          state_next = dcache_pkg::state_finish;
        end
      end
      dcache_pkg::state_finish: if (queue_empty) state_next = dcache_pkg::state_done;
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= dcache_pkg::state_idle;
      walk_index <= '0;
    end else begin
      state <= state_next;
      if (walk_write) begin
        walk_index <= walk_index + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/miss_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_queue (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  push_fill,
  input  wire dcache_pkg::addr_t     fill_req_addr,
  input  wire logic                  push_evict,
  input  wire dcache_pkg::addr_t     evict_addr,
  input  wire dcache_pkg::word_t     evict_data,
  input  wire logic                  fill_taken,
  input  wire mem_bus_pkg::mem_tag_t mem_response,
  input  wire mem_bus_pkg::mem_tag_t mem_tag,
  input  wire dcache_pkg::word_t     mem_rdata,
  output logic                       queue_full,
  output logic                       queue_empty,
  output logic                       fill_valid,
  output dcache_pkg::addr_t          fill_addr,
  output dcache_pkg::word_t          fill_data,
  output mem_bus_pkg::bus_command_t  mem_command,
  output dcache_pkg::addr_t          mem_addr,
  output dcache_pkg::word_t          mem_wdata
);

  // life of one entry, free doubles as retired
  typedef enum logic [1:0] {
    phase_free,
    phase_wait,
    phase_issued,
    phase_filled
  } phase_t;

  phase_t                entry_phase [dcache_pkg::queue_depth];
  logic                  entry_fill [dcache_pkg::queue_depth];
  dcache_pkg::addr_t     entry_addr [dcache_pkg::queue_depth];
  dcache_pkg::word_t     entry_data [dcache_pkg::queue_depth];
  mem_bus_pkg::mem_tag_t entry_tag [dcache_pkg::queue_depth];
  logic                  tag_hit [dcache_pkg::queue_depth];

  dcache_pkg::queue_ptr_t              head;
  dcache_pkg::queue_ptr_t              tail;
  dcache_pkg::queue_ptr_t              issue_ptr;
  dcache_pkg::queue_ptr_t              fill_ptr;
  logic [dcache_pkg::queue_ptr_bits:0] count;
  logic                                issue_valid;
  logic                                issue_accepted;
  logic                                duplicate;
  logic                                push_any;
  logic                                pop_head;

  assign queue_empty = (count == '0);
  assign queue_full = (count == dcache_pkg::queue_depth);

  // a fill for a line already in flight is dropped
  always_comb begin
    duplicate = 1'b0;
    for (int i = 0; i < dcache_pkg::queue_depth; i++) begin
      if (entry_phase[i] != phase_free && entry_fill[i] && entry_addr[i] == fill_req_addr) begin
        duplicate = 1'b1;
      end
      tag_hit[i] = (entry_phase[i] == phase_issued) && (mem_tag != mem_bus_pkg::no_tag) &&
                   (entry_tag[i] == mem_tag);
    end
  end

  assign push_any = !queue_full && (push_evict || (push_fill && !duplicate));
  assign pop_head = !queue_empty && (entry_phase[head] == phase_free);

  // oldest waiting entry goes on the bus, oldest filled entry goes back to the cache
  always_comb begin
    dcache_pkg::queue_ptr_t scan;
    issue_valid = 1'b0;
    issue_ptr = head;
    fill_valid = 1'b0;
    fill_ptr = head;
    for (int i = 0; i < dcache_pkg::queue_depth; i++) begin
      scan = head + dcache_pkg::queue_ptr_t'(i);
      if (!issue_valid && entry_phase[scan] == phase_wait) begin
        issue_valid = 1'b1;
        issue_ptr = scan;
      end
      if (!fill_valid && entry_phase[scan] == phase_filled) begin
        fill_valid = 1'b1;
        fill_ptr = scan;
      end
    end
  end

  always_comb begin
    mem_command = mem_bus_pkg::bus_none;
    if (issue_valid) begin
      mem_command = entry_fill[issue_ptr] ? mem_bus_pkg::bus_load : mem_bus_pkg::bus_store;
    end
  end

  assign issue_accepted = issue_valid && (mem_response != mem_bus_pkg::no_tag);
  assign mem_addr = entry_addr[issue_ptr];
  assign mem_wdata = entry_data[issue_ptr];
  assign fill_addr = entry_addr[fill_ptr];
  assign fill_data = entry_data[fill_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      for (int i = 0; i < dcache_pkg::queue_depth; i++) begin
        entry_phase[i] <= phase_free;
      end
    end else begin
      if (push_any) begin
        entry_phase[tail] <= phase_wait;
        tail <= tail + 1'b1;
      end
      // stores are done once memory accepts them
      if (issue_accepted) begin
        entry_phase[issue_ptr] <= entry_fill[issue_ptr] ? phase_issued : phase_free;
      end
      for (int i = 0; i < dcache_pkg::queue_depth; i++) begin
        if (tag_hit[i]) begin
          entry_phase[i] <= phase_filled;
        end
      end
      if (fill_taken && fill_valid) begin
        entry_phase[fill_ptr] <= phase_free;
      end
      if (pop_head) begin
        head <= head + 1'b1;
      end
      case ({push_any, pop_head})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push_any) begin
      entry_fill[tail] <= !push_evict;
      entry_addr[tail] <= push_evict ? evict_addr : fill_req_addr;
      entry_data[tail] <= evict_data;
    end
    if (issue_accepted) begin
      entry_tag[issue_ptr] <= mem_response;
    end
    for (int i = 0; i < dcache_pkg::queue_depth; i++) begin
      if (tag_hit[i]) begin
        entry_data[i] <= mem_rdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dcache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire dcache_pkg::addr_t load_addr,
  input  wire dcache_pkg::addr_t store_addr,
  input  wire logic              write_en,
  input  wire dcache_pkg::addr_t write_addr,
  input  wire dcache_pkg::word_t write_data,
  input  wire logic              write_dirty,
  input  wire logic              write_clean_only,
  output dcache_pkg::word_t      load_data,
  output logic                   load_match,
  output logic                   store_match,
  output logic                   victim_valid,
  output logic                   victim_dirty,
  output dcache_pkg::addr_t      victim_addr,
  output dcache_pkg::word_t      victim_data
);

  // per-line state
  logic              line_valid [dcache_pkg::num_lines];
  logic              line_dirty [dcache_pkg::num_lines];
  dcache_pkg::tag_t  line_tag [dcache_pkg::num_lines];
  dcache_pkg::word_t line_data [dcache_pkg::num_lines];

  dcache_pkg::index_t load_index;
  dcache_pkg::index_t store_index;
  dcache_pkg::index_t write_index;
  dcache_pkg::tag_t   load_tag;
  dcache_pkg::tag_t   store_tag;
  dcache_pkg::tag_t   write_tag;

  // address split
  assign load_index = load_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
  assign store_index = store_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
  assign write_index = write_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
  assign load_tag = load_addr[dcache_pkg::addr_bits-1 -: dcache_pkg::tag_bits];
  assign store_tag = store_addr[dcache_pkg::addr_bits-1 -: dcache_pkg::tag_bits];
  assign write_tag = write_addr[dcache_pkg::addr_bits-1 -: dcache_pkg::tag_bits];

  // lookups for the two processor ports
  assign load_match = line_valid[load_index] && (line_tag[load_index] == load_tag);
  assign load_data = line_data[load_index];
  assign store_match = line_valid[store_index] && (line_tag[store_index] == store_tag);

  // line currently sitting where the next write lands
  assign victim_valid = line_valid[write_index];
  assign victim_dirty = line_dirty[write_index];
  assign victim_addr = {line_tag[write_index], write_index, {dcache_pkg::offset_bits{1'b0}}};
  assign victim_data = line_data[write_index];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < dcache_pkg::num_lines; i++) begin
        line_valid[i] <= 1'b0;
        line_dirty[i] <= 1'b0;
      end
    end else if (write_en) begin
      // flush walk only cleans the line
      if (!write_clean_only) begin
        line_valid[write_index] <= 1'b1;
      end
      line_dirty[write_index] <= write_dirty && !write_clean_only;
    end
  end

  always_ff @(posedge clock) begin
    if (write_en && !write_clean_only) begin
      line_tag[write_index] <= write_tag;
      line_data[write_index] <= write_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

  localparam int mem_tag_bits = 4;

  // command driven by the cache toward memory
  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_command_t;

  // transaction tag, zero means no transaction
  typedef logic [mem_tag_bits-1:0] mem_tag_t;

  localparam mem_tag_t no_tag = '0;

endpackage

`default_nettype wire

// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

  // address and data widths
  localparam int addr_bits = 32;
  localparam int word_bits = 64;
  localparam int offset_bits = 3;

  // direct-mapped geometry, one word per line
  localparam int num_lines = 16;
  localparam int index_bits = 4;
  localparam int tag_bits = addr_bits - index_bits - offset_bits;

  // miss queue sizing
  localparam int queue_depth = 4;
  localparam int queue_ptr_bits = 2;

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [word_bits-1:0] word_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [queue_ptr_bits-1:0] queue_ptr_t;

  // last index visited by the flush walk
  localparam index_t last_index = index_t'(num_lines - 1);

  // flush sequence
  typedef enum logic [2:0] {
    state_idle,
    state_drain,
    state_walk,
    state_finish,
    state_done
  } flush_state_t;

endpackage

`default_nettype wire
